//--- common/erx_clk_params.svh
`ifndef ERX_CLK_PARAMS_SVH
`define ERX_CLK_PARAMS_SVH

// Heartbeat counter width, period is 2**RCW sys_clk cycles
`define ERX_RCW 4

// rx_clkin edges from PLL reset release to lock
`define ERX_LOCK_CYCLES 20

// rx_clkin edges from calibrator reset release to ready
`define ERX_DELAY_CYCLES 12

// Flop depth of every synchronizer
`define ERX_SYNC_STAGES 2

// Counter widths, sized to hold the full count
`define ERX_LOCK_CW  $clog2(`ERX_LOCK_CYCLES + 1)
`define ERX_DELAY_CW $clog2(`ERX_DELAY_CYCLES + 1)

`endif

//--- common/erx_clk_pkg.sv
`default_nettype none

package erx_clk_pkg;

   // ####################
   // Reset sequencer
   // ####################

   // Sequencer states, 3-bit encoding kept from the receiver
   typedef enum logic [2:0]
   {
      RX_RESET_ALL = 3'b000,   // PLL and calibrator held in reset
      RX_START_PLL = 3'b001,   // Waiting for lock and delay ready
      RX_ACTIVE    = 3'b010    // Receiver running
   } erx_reset_state_t;

   // ####################
   // PLL status
   // ####################

   // Both flags come from the rx_clkin domain
   // Synchronize before use on sys_clk
   typedef struct packed
   {
      logic locked;            // PLL lock after reset release
      logic delay_ready;       // Input-delay calibration done
   } erx_pll_status_t;

   // Only the pair matters to the sequencer
   // Bit order is locked in the MSB
   // Width check for the status bundle
   localparam int ERX_PLL_STATUS_W = $bits(erx_pll_status_t);

   // Width of the sequencer state
   localparam int ERX_STATE_W = $bits(erx_reset_state_t);

endpackage

`default_nettype wire

//--- hw/oh_rsync.sv
`timescale 1ns/1ps
`default_nettype none
`include "erx_clk_params.svh"

module oh_rsync
(
   input  logic clk,        // Destination clock
   input  logic nrst_in,    // Async active-low reset in
   output logic nrst_out    // Assert async, release synced to clk
);

   localparam int STAGES = `ERX_SYNC_STAGES;

   // ####################
   // Sync chain
   // ####################

   // Cleared at once by nrst_in
   // Ones shift in after release
   logic [STAGES-1:0] sync_q;

   always_ff @(posedge clk or negedge nrst_in)
   begin
      if (!nrst_in)
         sync_q <= '0;                         // Assert without clock
      else
         sync_q <= {sync_q[STAGES-2:0], 1'b1};  // Fill from the LSB
   end

   // Release after STAGES clk edges
   assign nrst_out = sync_q[STAGES-1];

endmodule

`default_nettype wire

//--- erx_clocks/erx_rx_pll.sv
`timescale 1ns/1ps
`default_nettype none
`include "erx_clk_params.svh"

module erx_rx_pll
   import erx_clk_pkg::*;
(
   input  logic            rx_clkin,       // Reference clock
   input  logic            pll_reset,      // Async, active high
   output logic            rx_lclk,        // Gated copy of rx_clkin
   output logic            rx_lclk_div4,   // Quarter rate of rx_lclk
   output erx_pll_status_t pll_status      // Lock and delay-ready
);

   localparam int LOCK_CW  = `ERX_LOCK_CW;
   localparam int DELAY_CW = `ERX_DELAY_CW;

   logic                locked_q;
   logic                dly_ready_q;
   logic [LOCK_CW-1:0]  lock_cnt;
   logic [DELAY_CW-1:0] dly_cnt;
   logic                gate_en;           // Falling-edge clock enable
   logic                div_phase;         // Toggles every rx_lclk edge
   logic                div4_q;

   // ####################
   // Lock counter
   // ####################

   // locked rises on the LOCK_CYCLES-th edge after release
   always_ff @(posedge rx_clkin or posedge pll_reset)
   begin
      if (pll_reset)
      begin
         lock_cnt <= '0;
         locked_q <= 1'b0;
      end
      else if (!locked_q)
      begin
         lock_cnt <= lock_cnt + 1'b1;
         if (lock_cnt == LOCK_CW'(`ERX_LOCK_CYCLES - 1))
            locked_q <= 1'b1;             // Sticky until next reset
      end
   end

   // ####################
   // Delay calibrator
   // ####################

   always_ff @(posedge rx_clkin or posedge pll_reset)
   begin
      if (pll_reset)
      begin
         dly_cnt     <= '0;
         dly_ready_q <= 1'b0;
      end
      else if (!dly_ready_q)
      begin
         dly_cnt <= dly_cnt + 1'b1;
         if (dly_cnt == DELAY_CW'(`ERX_DELAY_CYCLES - 1))
            dly_ready_q <= 1'b1;
      end
   end

   assign pll_status.locked      = locked_q;
   assign pll_status.delay_ready = dly_ready_q;

   // ####################
   // Clock gate
   // ####################

   // Enable changes only while rx_clkin is low
   always_ff @(negedge rx_clkin or posedge pll_reset)
   begin
      if (pll_reset)
         gate_en <= 1'b0;
      else
         gate_en <= locked_q;
   end

   assign rx_lclk = rx_clkin & gate_en;   // No runt pulses

   // Divide by four, toggle on every second rx_lclk edge
   always_ff @(posedge rx_lclk or posedge pll_reset)
   begin
      if (pll_reset)
      begin
         div_phase <= 1'b0;
         div4_q    <= 1'b0;
      end
      else
      begin
         div_phase <= ~div_phase;
         if (div_phase)
            div4_q <= ~div4_q;
      end
   end

   assign rx_lclk_div4 = div4_q;

   // Gate stays closed until lock
   a_gate_locked: assert property (@(posedge rx_clkin) disable iff (pll_reset)
      gate_en |-> locked_q);

endmodule

`default_nettype wire

//--- erx_clocks/erx_reset_seq.sv
`timescale 1ns/1ps
`default_nettype none
`include "erx_clk_params.svh"

module erx_reset_seq
   import erx_clk_pkg::*;
(
   input  logic            sys_clk,
   input  logic            rx_nreset_in,   // Async active-low reset
   input  logic            tx_active,      // Link up, low forces reset
   input  logic            soft_reset,     // Software disable
   input  erx_pll_status_t pll_status,     // From the PLL, rx_clkin domain
   output logic            pll_reset,      // PLL and calibrator reset
   output logic            rx_nreset,      // Registered receive reset
   output logic            rx_active       // Receiver running
);

   localparam int SYNC_STAGES = `ERX_SYNC_STAGES;

   // Reset either on hardware reset or on link drop
   logic seq_nreset;
   assign seq_nreset = rx_nreset_in & tx_active;

   // ####################
   // Heartbeat
   // ####################

   // Free-running, starts from its power-up value
   logic [`ERX_RCW-1:0] hb_count = '0;
   logic                heartbeat;         // One cycle every 2**RCW

   always_ff @(posedge sys_clk)
   begin
      hb_count  <= hb_count + 1'b1;
      heartbeat <= (hb_count == '0);      // Wrap detect
   end

   // ####################
   // Status sync
   // ####################

   // Both status bits cross together, each is a slow level
   erx_pll_status_t [SYNC_STAGES-1:0] status_pipe;
   erx_pll_status_t                   status_sync;

   always_ff @(posedge sys_clk or negedge seq_nreset)
   begin
      if (!seq_nreset)
         status_pipe <= '0;
      else
         status_pipe <= {status_pipe[SYNC_STAGES-2:0], pll_status};
   end

   assign status_sync = status_pipe[SYNC_STAGES-1];   // Last stage

   // ####################
   // Sequencer FSM
   // ####################

   erx_reset_state_t state_q;
   erx_reset_state_t state_d;

   always_comb
   begin
      state_d = state_q;                  // Hold between heartbeats
      if (heartbeat)
      begin
         case (state_q)
            RX_RESET_ALL:
               if (!soft_reset)
                  state_d = RX_START_PLL;
            RX_START_PLL:
               if (status_sync.locked && status_sync.delay_ready)
                  state_d = RX_ACTIVE;
            RX_ACTIVE:
               if (soft_reset)
                  state_d = RX_RESET_ALL;  // Wait here for soft_reset low
            default:
               state_d = RX_RESET_ALL;     // Recover from bad encoding
         endcase
      end
   end

   always_ff @(posedge sys_clk or negedge seq_nreset)
   begin
      if (!seq_nreset)
         state_q <= RX_RESET_ALL;
      else
         state_q <= state_d;
   end

   // State decode
   assign rx_active = (state_q == RX_ACTIVE);
   assign pll_reset = (state_q == RX_RESET_ALL);   // Calibrator shares it

   // Receive reset, one cycle behind rx_active
   always_ff @(posedge sys_clk or negedge seq_nreset)
   begin
      if (!seq_nreset)
         rx_nreset <= 1'b0;
      else
         rx_nreset <= rx_active;
   end

   // ####################
   // Assertions
   // ####################

   // Only the three legal encodings
   a_state_legal: assert property (@(posedge sys_clk) disable iff (!seq_nreset)
      state_q inside {RX_RESET_ALL, RX_START_PLL, RX_ACTIVE});

   // Entry into RX_ACTIVE only on a heartbeat with synced lock
   a_active_locked: assert property (@(posedge sys_clk) disable iff (!seq_nreset)
      $rose(rx_active) |-> $past(heartbeat && status_sync.locked));

   // PLL never held in reset while the receiver runs
   a_reset_excl: assert property (@(posedge sys_clk) disable iff (!seq_nreset)
      !(pll_reset && rx_active));

endmodule

`default_nettype wire

//--- erx_clocks/erx_clocks.sv
`timescale 1ns/1ps
`default_nettype none

module erx_clocks
   import erx_clk_pkg::*;
(
   // Always-on system side
   input  logic sys_clk,         // System clock, runs the sequencer
   input  logic rx_nreset_in,    // Async active-low hardware reset
   input  logic soft_reset,      // Software disable of the receiver
   input  logic tx_active,       // Link partner transmitting
   // Receive reference
   input  logic rx_clkin,        // Reference clock for the receive PLL
   // Receive clocks
   output logic rx_lclk,         // Fast receive clock for the IO
   output logic rx_lclk_div4,    // Quarter-rate logic clock
   // Status and resets
   output logic rx_active,       // Sequencer in RX_ACTIVE
   output logic erx_nreset,      // Core reset, released on rx_lclk_div4
   output logic erx_io_nreset    // IO reset, released on rx_lclk
);

   // ####################
   // Internal nets
   // ####################

   logic            pll_reset;   // Holds PLL and calibrator in reset
   logic            rx_nreset;   // Registered receive reset, sys_clk domain
   erx_pll_status_t pll_status;  // Lock and delay-ready, rx_clkin domain

   // ####################
   // Reset sequencer
   // ####################

   erx_reset_seq u_reset_seq
   (
      .sys_clk      (sys_clk),
      .rx_nreset_in (rx_nreset_in),
      .tx_active    (tx_active),
      .soft_reset   (soft_reset),
      .pll_status   (pll_status),
      .pll_reset    (pll_reset),
      .rx_nreset    (rx_nreset),
      .rx_active    (rx_active)
   );

   // ####################
   // Receive PLL
   // ####################

   erx_rx_pll u_rx_pll
   (
      .rx_clkin     (rx_clkin),
      .pll_reset    (pll_reset),
      .rx_lclk      (rx_lclk),
      .rx_lclk_div4 (rx_lclk_div4),
      .pll_status   (pll_status)
   );

   // ####################
   // Reset synchronizers
   // ####################

   // IO side, fast clock
   oh_rsync u_rsync_io
   (
      .clk      (rx_lclk),
      .nrst_in  (rx_nreset),
      .nrst_out (erx_io_nreset)
   );

   // Core side, quarter-rate clock
   oh_rsync u_rsync_core
   (
      .clk      (rx_lclk_div4),
      .nrst_in  (rx_nreset),
      .nrst_out (erx_nreset)
   );

endmodule

`default_nettype wire

//--- bench/tb_erx_clocks.sv
`timescale 1ns/1ps
`default_nettype none

module tb_erx_clocks;

   localparam int TIMEOUT_CYCLES = 500;   // Longest wait in sys_clk cycles
   localparam int RSYNC_LIMIT    = 15;    // 10 rx_clkin periods in sys_clk cycles
   localparam int HB_CYCLES      = 16;    // One heartbeat

   // Output selectors for the wait loop
   localparam int SIG_ACTIVE    = 0;
   localparam int SIG_NRESET    = 1;
   localparam int SIG_IO_NRESET = 2;

   logic sys_clk;
   logic rx_clkin;
   logic rx_nreset_in;
   logic soft_reset;
   logic tx_active;
   logic rx_lclk;
   logic rx_lclk_div4;
   logic rx_active;
   logic erx_nreset;
   logic erx_io_nreset;

   int error_count;
   int test_count;
   int test_errors;   // error_count when the current test began
   int lclk_edges;
   int div4_edges;
   int seed;
   int round;

   erx_clocks u_dut
   (
      .sys_clk       (sys_clk),
      .rx_nreset_in  (rx_nreset_in),
      .soft_reset    (soft_reset),
      .tx_active     (tx_active),
      .rx_clkin      (rx_clkin),
      .rx_lclk       (rx_lclk),
      .rx_lclk_div4  (rx_lclk_div4),
      .rx_active     (rx_active),
      .erx_nreset    (erx_nreset),
      .erx_io_nreset (erx_io_nreset)
   );

   // ####################
   // Clocks and counters
   // ####################

   always #2 sys_clk = ~sys_clk;   // 4 ns

   // 6 ns period on a half-ns phase
   // Keeps rx edges off the sys_clk grid
   always
   begin
      #1.5;
      rx_clkin = ~rx_clkin;
      #1.5;
   end

   always @(posedge rx_lclk) lclk_edges = lclk_edges + 1;
   always @(posedge rx_lclk_div4) div4_edges = div4_edges + 1;

   // ####################
   // Helpers
   // ####################

   function automatic logic read_output(input int which);
      case (which)
         SIG_ACTIVE: return rx_active;
         SIG_NRESET: return erx_nreset;
         default:    return erx_io_nreset;
      endcase
   endfunction

   // Ends 1 ns after a rising sys_clk edge
   task automatic drive_cycles(input int n);
      repeat (n) @(posedge sys_clk);
      #1;
   endtask

   // Poll on falling sys_clk where every output is settled
   task automatic wait_level(input int which, input logic value, input int limit,
                             output int waited, output bit found);
      found  = 1'b0;
      waited = 0;
      while (!found && waited < limit)
      begin
         @(negedge sys_clk);
         waited = waited + 1;
         if (read_output(which) === value)
            found = 1'b1;
      end
   endtask

   // Window between falling rx_clkin edges
   // Both counters settled at each end
   task automatic count_edges(input int rx_periods);
      @(negedge rx_clkin);
      lclk_edges = 0;
      div4_edges = 0;
      repeat (rx_periods) @(posedge rx_clkin);
      @(negedge rx_clkin);
   endtask

   task automatic check_value(input string test, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("[ERROR] %s: %s expected %0d actual %0d", test, what, expected, actual);
         error_count = error_count + 1;
      end
   endtask

   task automatic report_problem(input string test, input string what);
      $display("%s: %s", test, what);
      error_count = error_count + 1;
   endtask

   task automatic finish_test(input string test);
      test_count = test_count + 1;
      if (error_count == test_errors)
         $display("test %s done, no errors", test);
      else
         $display("test %s done, %0d errors", test, error_count - test_errors);
      test_errors = error_count;
   endtask

   // rx_active, then io reset, then core reset
   task automatic await_bring_up(input string test);
      int  waited;
      bit  found;
      int  io_wait;
      wait_level(SIG_ACTIVE, 1'b1, TIMEOUT_CYCLES, waited, found);
      if (!found)
      begin
         report_problem(test, "rx_active never rose");
      end
      else
      begin
         wait_level(SIG_IO_NRESET, 1'b1, RSYNC_LIMIT, io_wait, found);
         if (!found)
            report_problem(test, "erx_io_nreset did not rise within 10 rx_clkin periods");
         else
            check_value(test, "erx_nreset at io release", 0, erx_nreset);   // Core comes later
         wait_level(SIG_NRESET, 1'b1, RSYNC_LIMIT - io_wait, waited, found);
         if (!found)
            report_problem(test, "erx_nreset did not rise within 10 rx_clkin periods");
         check_value(test, "erx_io_nreset", 1, erx_io_nreset);
         check_value(test, "rx_active", 1, rx_active);
      end
   endtask

   // ####################
   // Tests
   // ####################

   task automatic test_reset();
      @(negedge sys_clk);   // Still inside reset
      check_value("reset", "rx_active in reset", 0, rx_active);
      check_value("reset", "erx_nreset in reset", 0, erx_nreset);
      check_value("reset", "erx_io_nreset in reset", 0, erx_io_nreset);
      drive_cycles(2);      // Third rising edge
      rx_nreset_in = 1'b1;
      lclk_edges   = 0;
      repeat (40) @(negedge sys_clk);
      check_value("reset", "rx_active", 0, rx_active);
      check_value("reset", "erx_nreset", 0, erx_nreset);
      check_value("reset", "erx_io_nreset", 0, erx_io_nreset);
      check_value("reset", "rx_lclk edges", 0, lclk_edges);
      finish_test("reset");
   endtask

   task automatic test_bring_up();
      drive_cycles(1);
      soft_reset = 1'b0;
      await_bring_up("bring_up");
      finish_test("bring_up");
   endtask

   task automatic test_ratio();
      count_edges(16);
      check_value("ratio", "rx_lclk edges", 16, lclk_edges);
      check_value("ratio", "rx_lclk_div4 edges", 4, div4_edges);
      finish_test("ratio");
   endtask

   task automatic test_soft_shutdown();
      int hold;
      int waited;
      bit found;
      hold = 20 + ($urandom % 61);   // 20 to 80 cycles
      drive_cycles(1);
      soft_reset = 1'b1;
      wait_level(SIG_ACTIVE, 1'b0, HB_CYCLES, waited, found);
      if (!found)
         report_problem("soft_shutdown", "rx_active still high one heartbeat after soft_reset");
      @(negedge sys_clk);   // rx_nreset trails by one cycle
      check_value("soft_shutdown", "erx_nreset", 0, erx_nreset);
      check_value("soft_shutdown", "erx_io_nreset", 0, erx_io_nreset);
      repeat (3) @(posedge rx_clkin);
      count_edges(8);
      check_value("soft_shutdown", "rx_lclk edges after stop", 0, lclk_edges);
      drive_cycles(hold);
      check_value("soft_shutdown", "rx_active during hold", 0, rx_active);
      soft_reset = 1'b0;
      await_bring_up("soft_shutdown");
      finish_test("soft_shutdown");
   endtask

   task automatic test_link_drop();
      bit stayed_low;
      drive_cycles(1);
      tx_active = 1'b0;
      @(negedge sys_clk);   // 1 ns later via the async path
      check_value("link_drop", "rx_active", 0, rx_active);
      stayed_low = 1'b1;
      repeat (40)
      begin
         @(negedge sys_clk);
         if (rx_active !== 1'b0)
            stayed_low = 1'b0;
      end
      if (!stayed_low)
         report_problem("link_drop", "rx_active came back while tx_active was low");
      check_value("link_drop", "erx_nreset", 0, erx_nreset);
      check_value("link_drop", "erx_io_nreset", 0, erx_io_nreset);
      drive_cycles(1);
      tx_active = 1'b1;
      await_bring_up("link_drop");
      finish_test("link_drop");
   endtask

   // ####################
   // Main sequence
   // ####################

   initial
   begin
      sys_clk      = 1'b0;
      rx_clkin     = 1'b0;
      rx_nreset_in = 1'b0;   // In reset
      soft_reset   = 1'b1;   // Receiver held off
      tx_active    = 1'b1;
      error_count  = 0;
      test_count   = 0;
      test_errors  = 0;
      lclk_edges   = 0;
      div4_edges   = 0;
      seed         = 93;
      void'($urandom(seed));

      test_reset();
      test_bring_up();
      test_ratio();
      for (round = 0; round < 2; round++)
      begin
         test_soft_shutdown();
         test_ratio();
      end
      test_link_drop();
      test_ratio();

      $display("tests run %0d, errors %0d", test_count, error_count);
      if (error_count == 0)
      begin
         $display("Simulation passed");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/erx_clk_pkg.sv
hw/oh_rsync.sv
erx_clocks/erx_rx_pll.sv
erx_clocks/erx_reset_seq.sv
erx_clocks/erx_clocks.sv
bench/tb_erx_clocks.sv

//--- Bender.yml
package:
  name: erx_clocks

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/erx_clk_pkg.sv
      - hw/oh_rsync.sv
      - erx_clocks/erx_rx_pll.sv
      - erx_clocks/erx_reset_seq.sv
      - erx_clocks/erx_clocks.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - bench/tb_erx_clocks.sv
